/* compile.f */
+incdir+logic
logic/fetch_pkg.sv
logic/branch_target_buffer.sv
logic/local_predictor.sv
logic/branch_queue.sv
logic/fetch_fsm.sv
logic/pc_counter.sv
logic/fetch_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_fetch_unit.sv

/* logic/branch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module branch_queue (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   push,
  input  fetch_pkg::branch_rec_t push_rec,
  input  logic                   pop,
  input  logic                   flush,
  output fetch_pkg::branch_rec_t head,
  output logic                   empty
);

  import fetch_pkg::*;

  localparam int DEPTH = `FETCH_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  branch_rec_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;

  assign empty = (count == '0);
  assign full  = (count == (PTR_W+1)'(DEPTH));
  assign head  = mem[rd_ptr]; // oldest branch

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (flush)
    begin
      wr_ptr <= '0; // drops the push of the same cycle too
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
    end
  end

  always_ff @(posedge clk)
  begin
    if (push && !flush)
      mem[wr_ptr] <= push_rec;
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    !(push && full && !pop && !flush))
    else $error("branch queue overflow");

  // execute only resolves branches that fetch has queued
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    pop |-> !empty)
    else $error("resolve with no branch in flight");

endmodule

`default_nettype wire

/* logic/branch_target_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module branch_target_buffer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`FETCH_XLEN-1:0] pc,
  output logic                   hit,
  output logic [`FETCH_XLEN-1:0] target,
  input  logic                   wr_en,
  input  logic [`FETCH_XLEN-1:0] wr_pc,
  input  logic [`FETCH_XLEN-1:0] wr_target
);

  localparam int XLEN  = `FETCH_XLEN;
  localparam int IDX_W = `FETCH_BTB_IDX_W;
  localparam int TAG_W = XLEN - IDX_W - 2;
  localparam int DEPTH = 1 << IDX_W;

  logic [DEPTH-1:0] valid_q;
  logic [TAG_W-1:0] tag_mem [DEPTH];
  logic [XLEN-1:0]  tgt_mem [DEPTH];

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;

  assign rd_idx = pc[IDX_W+1:2];
  assign rd_tag = pc[XLEN-1:IDX_W+2]; // bits above the index
  assign wr_idx = wr_pc[IDX_W+1:2];
  assign wr_tag = wr_pc[XLEN-1:IDX_W+2];

  assign hit    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign target = tgt_mem[rd_idx];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_q <= '0;
    end
    else if (wr_en)
    begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      tag_mem[wr_idx] <= wr_tag;
      tgt_mem[wr_idx] <= wr_target; // last taken target wins
    end
  end

endmodule

`default_nettype wire

/* logic/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// address width
`define FETCH_XLEN 32

// btb index, pc[7:2]
`define FETCH_BTB_IDX_W 6

// history table index, pc[5:2]
`define FETCH_LHT_IDX_W 4

// local history bits, also the pattern table index
`define FETCH_HIST_W 4

// branches in flight
`define FETCH_QUEUE_DEPTH 8

// reset vector
`define FETCH_RESET_PC 32'h0000_0000

// bytes per instruction
`define FETCH_PC_STEP 4

`endif

/* logic/fetch_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_fsm (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   resolve_valid,
  input  fetch_pkg::resolve_t    resolve,
  input  fetch_pkg::branch_rec_t head,
  input  fetch_pkg::pred_t       pred,
  output fetch_pkg::pc_sel_e     pc_sel,
  output logic [`FETCH_XLEN-1:0] redirect_pc,
  output logic                   redirect,
  output logic                   flush,
  output logic                   pop,
  output logic                   fetch_valid
);

  import fetch_pkg::*;

  localparam logic [`FETCH_XLEN-1:0] PC_STEP = `FETCH_PC_STEP;

  fsm_state_e state_q;
  fsm_state_e state_d;
  logic       dir_miss;
  logic       tgt_miss;
  logic       mispredict;

  assign dir_miss   = resolve.taken != head.pred.taken;
  assign tgt_miss   = resolve.taken && head.pred.taken && (resolve.target != head.pred.target);
  assign mispredict = resolve_valid && (state_q == ST_RUN) && (dir_miss || tgt_miss);

  assign redirect_pc = resolve.taken ? resolve.target : head.pc + PC_STEP;

  always_comb
  begin
    state_d = state_q;
    pc_sel  = PC_HOLD;
    case (state_q)
      ST_RUN:
      begin
        if (mispredict)
        begin
          state_d = ST_FLUSH;
          pc_sel  = PC_REDIRECT; // beats the fetch prediction
        end
        else if (pred.taken)
          pc_sel = PC_PRED;
        else
          pc_sel = PC_SEQ;
      end
      ST_FLUSH:
      begin
        state_d = ST_RUN; // pc already holds the corrected target
      end
      default:
      begin
        state_d = ST_RUN;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state_q <= ST_RUN;
    else
      state_q <= state_d;
  end

  assign fetch_valid = (state_q == ST_RUN);
  assign redirect    = (state_q == ST_FLUSH);
  assign flush       = mispredict; // queue empty from the next cycle
  assign pop         = resolve_valid;

endmodule

`default_nettype wire

/* logic/fetch_pkg.sv */
`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

  typedef enum logic [1:0] {
    BR_NONE = 2'b00,
    BR_COND = 2'b01,
    BR_JUMP = 2'b10
  } br_kind_e;

  // outcome from execute
  typedef struct packed {
    logic                   taken;
    logic [`FETCH_XLEN-1:0] target;
  } resolve_t;

  typedef struct packed {
    logic                   taken;
    logic [`FETCH_XLEN-1:0] target;
  } pred_t;

  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;
    br_kind_e               kind;
    pred_t                  pred;
  } branch_rec_t;

  typedef enum logic {
    ST_RUN   = 1'b0,
    ST_FLUSH = 1'b1
  } fsm_state_e;

  typedef enum logic [1:0] {
    PC_SEQ      = 2'b00,
    PC_PRED     = 2'b01,
    PC_REDIRECT = 2'b10,
    PC_HOLD     = 2'b11
  } pc_sel_e;

endpackage

`default_nettype wire

/* logic/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  fetch_pkg::br_kind_e    fetch_kind,
  input  logic                   resolve_valid,
  input  fetch_pkg::resolve_t    resolve,
  output logic [`FETCH_XLEN-1:0] pc,
  output logic                   fetch_valid,
  output fetch_pkg::pred_t       pred,
  output logic                   redirect
);

  import fetch_pkg::*;

  localparam logic [`FETCH_XLEN-1:0] PC_STEP = `FETCH_PC_STEP;

  logic                   btb_hit;
  logic [`FETCH_XLEN-1:0] btb_target;
  logic                   taken_hint;
  pc_sel_e                pc_sel;
  logic [`FETCH_XLEN-1:0] redirect_pc;
  logic                   flush;
  logic                   pop;
  logic                   push;
  branch_rec_t            head;
  branch_rec_t            push_rec;
  logic                   btb_wr_en;
  logic                   train_en;

  always_comb
  begin
    pred.taken  = btb_hit && ((fetch_kind == BR_JUMP) || ((fetch_kind == BR_COND) && taken_hint));
    pred.target = btb_hit ? btb_target : pc + PC_STEP;
    push_rec    = '{pc: pc, kind: fetch_kind, pred: pred};
  end

  assign push      = fetch_valid && (fetch_kind != BR_NONE);
  assign btb_wr_en = resolve_valid && resolve.taken; // only taken branches allocate
  assign train_en  = resolve_valid && (head.kind == BR_COND);

  branch_target_buffer u_btb (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .hit       (btb_hit),
    .target    (btb_target),
    .wr_en     (btb_wr_en),
    .wr_pc     (head.pc),
    .wr_target (resolve.target)
  );

  local_predictor u_pred (
    .clk         (clk),
    .rst         (rst),
    .pc          (pc),
    .taken_hint  (taken_hint),
    .train_en    (train_en),
    .train_pc    (head.pc),
    .train_taken (resolve.taken),
    .redirect    (redirect)
  );

  branch_queue u_queue (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .push_rec (push_rec),
    .pop      (pop),
    .flush    (flush),
    .head     (head),
    .empty    ()
  );

  fetch_fsm u_fsm (
    .clk           (clk),
    .rst           (rst),
    .resolve_valid (resolve_valid),
    .resolve       (resolve),
    .head          (head),
    .pred          (pred),
    .pc_sel        (pc_sel),
    .redirect_pc   (redirect_pc),
    .redirect      (redirect),
    .flush         (flush),
    .pop           (pop),
    .fetch_valid   (fetch_valid)
  );

  pc_counter u_pc (
    .clk         (clk),
    .rst         (rst),
    .pc_sel      (pc_sel),
    .pred_target (pred.target),
    .redirect_pc (redirect_pc),
    .pc          (pc)
  );

endmodule

`default_nettype wire

/* logic/local_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module local_predictor (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`FETCH_XLEN-1:0] pc,
  output logic                   taken_hint,
  input  logic                   train_en,
  input  logic [`FETCH_XLEN-1:0] train_pc,
  input  logic                   train_taken,
  input  logic                   redirect
);

  localparam int IDX_W     = `FETCH_LHT_IDX_W;
  localparam int HIST_W    = `FETCH_HIST_W;
  localparam int LHT_DEPTH = 1 << IDX_W;
  localparam int PHT_DEPTH = 1 << HIST_W;

  logic [HIST_W-1:0] lht_q [LHT_DEPTH];
  logic [1:0]        pht_q [PHT_DEPTH];

  logic [IDX_W-1:0]  rd_idx;
  logic [HIST_W-1:0] rd_hist;
  logic [IDX_W-1:0]  tr_idx;
  logic [HIST_W-1:0] tr_hist;
  logic [1:0]        tr_ctr;
  logic [1:0]        tr_ctr_next;

  assign rd_idx     = pc[IDX_W+1:2];
  assign rd_hist    = lht_q[rd_idx];
  assign taken_hint = pht_q[rd_hist][1]; // counter msb

  assign tr_idx  = train_pc[IDX_W+1:2];
  assign tr_hist = lht_q[tr_idx];
  assign tr_ctr  = pht_q[tr_hist];

  always_comb
  begin
    tr_ctr_next = tr_ctr;
    if (train_taken && (tr_ctr != 2'b11))
      tr_ctr_next = tr_ctr + 2'd1;
    else if (!train_taken && (tr_ctr != 2'b00))
      tr_ctr_next = tr_ctr - 2'd1;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < LHT_DEPTH; i++)
        lht_q[i] <= '0;
      for (int j = 0; j < PHT_DEPTH; j++)
        pht_q[j] <= 2'b01; // weakly not taken
    end
    else if (train_en)
    begin
      pht_q[tr_hist] <= tr_ctr_next;
      lht_q[tr_idx]  <= {tr_hist[HIST_W-2:0], train_taken};
    end
  end

  // a resolve during the flush cycle would train on a discarded record
  a_no_train_in_flush: assert property (@(posedge clk) disable iff (rst)
    !(train_en && redirect))
    else $error("predictor trained while the front end is flushing");

endmodule

`default_nettype wire

/* logic/pc_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module pc_counter (
  input  logic                   clk,
  input  logic                   rst,
  input  fetch_pkg::pc_sel_e     pc_sel,
  input  logic [`FETCH_XLEN-1:0] pred_target,
  input  logic [`FETCH_XLEN-1:0] redirect_pc,
  output logic [`FETCH_XLEN-1:0] pc
);

  import fetch_pkg::*;

  localparam logic [`FETCH_XLEN-1:0] PC_STEP = `FETCH_PC_STEP;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      pc <= `FETCH_RESET_PC;
    end
    else
    begin
      case (pc_sel)
        PC_SEQ:      pc <= pc + PC_STEP;
        PC_PRED:     pc <= pred_target;
        PC_REDIRECT: pc <= redirect_pc;
        default:     pc <= pc; // hold during flush
      endcase
    end
  end

  // targets come from the btb and from execute
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00)
    else $error("fetch pc not word aligned: %h", pc);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_fetch_unit -f compile.f \
  -o tb_fetch_unit && ./obj_dir/tb_fetch_unit > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST RESULT: FAIL" sim.log 2>/dev/null && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log 2>/dev/null || { echo "simulation did not pass"; exit 1; }
echo "simulation passed"
exit 0

/* testbench/fetch_stim.txt */
// kind_rvalid_rtaken_rtarget_pc_fetchvalid_predtaken_predtarget_redirect, one line per cycle
// kind 0 none 1 cond 2 jump, pc 0x10 jump to 0x50, 0x50 cond self loop, 0x58 jump to 0x10
0_0_0_00000000_00000000_1_0_00000004_0
0_0_0_00000000_00000004_1_0_00000008_0
0_0_0_00000000_00000008_1_0_0000000c_0
0_0_0_00000000_0000000c_1_0_00000010_0
2_0_0_00000000_00000010_1_0_00000014_0
0_1_1_00000050_00000014_1_0_00000018_0
1_0_0_00000000_00000050_0_0_00000054_1
1_0_0_00000000_00000050_1_0_00000054_0
0_1_1_00000050_00000054_1_0_00000058_0
1_0_0_00000000_00000050_0_0_00000050_1
1_0_0_00000000_00000050_1_0_00000050_0
0_1_1_00000050_00000054_1_0_00000058_0
1_0_0_00000000_00000050_0_0_00000050_1
1_0_0_00000000_00000050_1_0_00000050_0
0_1_1_00000050_00000054_1_0_00000058_0
1_0_0_00000000_00000050_0_0_00000050_1
1_0_0_00000000_00000050_1_0_00000050_0
0_1_1_00000050_00000054_1_0_00000058_0
1_0_0_00000000_00000050_0_0_00000050_1
1_0_0_00000000_00000050_1_0_00000050_0
0_1_1_00000050_00000054_1_0_00000058_0
1_0_0_00000000_00000050_0_1_00000050_1
1_0_0_00000000_00000050_1_1_00000050_0
1_0_0_00000000_00000050_1_1_00000050_0
1_1_1_00000050_00000050_1_1_00000050_0
1_1_1_00000050_00000050_1_1_00000050_0
1_1_0_00000000_00000050_1_1_00000050_0
0_0_0_00000000_00000054_0_0_00000058_1
0_0_0_00000000_00000054_1_0_00000058_0
2_0_0_00000000_00000058_1_0_0000005c_0
0_1_1_00000010_0000005c_1_0_00000060_0
2_0_0_00000000_00000010_0_1_00000050_1
2_0_0_00000000_00000010_1_1_00000050_0
1_1_1_00000050_00000050_1_0_00000050_0
0_1_0_00000000_00000054_1_0_00000058_0
2_0_0_00000000_00000058_1_1_00000010_0
2_1_1_00000010_00000010_1_1_00000050_0
// end marker
f_0_0_00000000_00000000_0_0_00000000_0

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  localparam time HALF_PERIOD = 5ns; // 10 ns period

  initial
  begin
    clk = 1'b0;
    forever
      #HALF_PERIOD clk = ~clk;
  end

endmodule

`default_nettype wire

/* testbench/tb_fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module tb_fetch_unit;

  import fetch_pkg::*;

  localparam int          VEC_W          = 120;
  localparam int          MAX_VEC        = 64;
  localparam int          RESET_CYCLES   = 10;
  localparam int          TIMEOUT_MARGIN = 20;
  localparam logic [31:0] SEED           = 32'h3bdd5f74;

  logic                   clk;
  logic                   rst;
  br_kind_e               fetch_kind;
  logic                   resolve_valid;
  resolve_t               resolve;
  logic [`FETCH_XLEN-1:0] pc;
  logic                   fetch_valid;
  pred_t                  pred;
  logic                   redirect;

  logic [VEC_W-1:0] stim_mem [MAX_VEC];
  int               num_vec;
  int               cur_cycle;
  int               cycle_count = 0;
  int               cycle_limit = 1000;

  tb_clock_gen i_clk_gen (
    .clk (clk)
  );

  fetch_unit i_dut (
    .clk           (clk),
    .rst           (rst),
    .fetch_kind    (fetch_kind),
    .resolve_valid (resolve_valid),
    .resolve       (resolve),
    .pc            (pc),
    .fetch_valid   (fetch_valid),
    .pred          (pred),
    .redirect      (redirect)
  );

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s in cycle %0d: got %h, expected %h", name, cur_cycle, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // one hex digit or eight per field of kind rv rt rtgt pc fv pt ptgt rd
  task automatic drive_vector(input logic [VEC_W-1:0] vec);
    logic [31:0] filler;
    filler = $urandom;
    fetch_kind    <= br_kind_e'(vec[117:116]);
    resolve_valid <= vec[112];
    resolve.taken <= vec[108];
    if (vec[112])
      resolve.target <= vec[107:76];
    else
      resolve.target <= {filler[31:2], 2'b00}; // don't care without the strobe
  endtask

  task automatic check_outputs(input logic [VEC_W-1:0] vec);
    compare_value("pc", pc, vec[75:44]);
    compare_value("fetch_valid", {31'b0, fetch_valid}, {31'b0, vec[40]});
    compare_value("pred.taken", {31'b0, pred.taken}, {31'b0, vec[36]});
    compare_value("pred.target", pred.target, vec[35:4]);
    compare_value("redirect", {31'b0, redirect}, {31'b0, vec[0]});
  endtask

  task automatic run_vectors();
    for (int i = 0; i < num_vec; i++)
    begin
      cur_cycle = i;
      drive_vector(stim_mem[i]);
      @(negedge clk); // outputs settled mid cycle
      check_outputs(stim_mem[i]);
      @(posedge clk);
    end
  endtask

  initial
  begin
    rst           = 1'b1;
    fetch_kind    = BR_NONE;
    resolve_valid = 1'b0;
    resolve       = '0;
    cur_cycle     = 0;
    void'($urandom(SEED));
    $readmemh("testbench/fetch_stim.txt", stim_mem);
    num_vec = 0;
    while ((num_vec < MAX_VEC) && (stim_mem[num_vec][119:116] != 4'hf))
      num_vec++;
    if ((num_vec == 0) || (num_vec == MAX_VEC))
    begin
      $display("stimulus file has no vectors or lacks its end marker line");
      $display("TEST RESULT: FAIL");
      $fatal(1, "cannot run without stimulus");
    end
    else
    begin
      cycle_limit = num_vec + TIMEOUT_MARGIN; // reset cycles fit in the margin
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      run_vectors();
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("timeout: the run went past %0d clock cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation did not finish in time");
    end
  end

endmodule

`default_nettype wire
